//--- cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

	localparam int way_addr_w = 26;
	localparam int upper_addr_w = 6; // nonzero selects I/O space
	localparam int stack_addr_w = 16;
	localparam int stack_size_w = 3; // counted in halfwords
	localparam int exec_idx_w = 2;
	localparam int line_halfwords = 8;

	typedef enum logic [2:0] {
		kind_idle = 3'd0,
		kind_stack_first = 3'd1, // split stack access, lower line
		kind_stack_second = 3'd2, // split stack access, upper line
		kind_stack_single = 3'd3,
		kind_general = 3'd4,
		kind_ifetch = 3'd5
	} state_kind_e;

	typedef struct packed {
		state_kind_e kind;
		logic [exec_idx_w-1:0] exec_idx;
	} ctrl_state_t;

	// one executer's request levels and payload
	typedef struct packed {
		logic stack_req;
		logic general_req;
		logic stack_write;
		logic general_write;
		logic byte_op;
		logic [stack_size_w-1:0] stack_size;
		logic [stack_addr_w-1:0] stack_addr;
		logic [upper_addr_w+way_addr_w-1:0] general_addr;
	} exec_req_t;

	typedef enum logic [1:0] {
		mask_first_lane = 2'd0,
		mask_second_lane = 2'd1,
		mask_general = 2'd2,
		mask_fetch = 2'd3
	} mask_type_e;

endpackage

`default_nettype wire

//--- cache_access_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cache_access_arbiter #(
	parameter int n_exec = 4
) (
	input  cache_ctrl_pkg::exec_req_t exec_req [n_exec],
	input  logic fetch_req,
	input  logic allow, // current access completes or the controller is idle
	input  cache_ctrl_pkg::ctrl_state_t skip,
	output logic grant_valid,
	output cache_ctrl_pkg::ctrl_state_t next_granted,
	output logic [n_exec-1:0] dependency_clear
);

	import cache_ctrl_pkg::*;

	localparam int off_w = $clog2(line_halfwords);
	localparam int sum_w = off_w + 1;

	logic skip_is_stack;
	logic [n_exec-1:0] want_stack;
	logic [n_exec-1:0] want_general;
	logic [n_exec-1:0] crosses_line;

	assign skip_is_stack = skip.kind inside {kind_stack_first, kind_stack_second,
		kind_stack_single};

	for (genvar i = 0; i < n_exec; i++) begin : g_exec
		localparam logic [exec_idx_w-1:0] idx = exec_idx_w'(i);

		logic [sum_w-1:0] end_offset;

		assign want_stack[i] = exec_req[i].stack_req &&
			!(skip_is_stack && skip.exec_idx == idx);
		assign want_general[i] = exec_req[i].general_req &&
			!(skip.kind == kind_general && skip.exec_idx == idx);
		assign end_offset = {1'b0, exec_req[i].stack_addr[off_w:1]} +
			sum_w'(exec_req[i].stack_size); // halfword offset plus size
		assign crosses_line[i] = end_offset > sum_w'(line_halfwords);
	end

	// walk from lowest to highest priority so the last hit wins
	always_comb begin
		grant_valid = 1'b0;
		next_granted = '{kind: kind_idle, exec_idx: '0};
		dependency_clear = '0;
		if (allow) begin
			if (fetch_req && skip.kind != kind_ifetch) begin
				grant_valid = 1'b1;
				next_granted.kind = kind_ifetch;
			end
			for (int i = n_exec - 1; i >= 0; i--) begin
				if (want_general[i]) begin
					grant_valid = 1'b1;
					next_granted = '{kind: kind_general, exec_idx: exec_idx_w'(i)};
					dependency_clear = '0;
					dependency_clear[i] = 1'b1;
				end
				if (want_stack[i]) begin
					grant_valid = 1'b1;
					next_granted.kind = crosses_line[i] ? kind_stack_first : kind_stack_single;
					next_granted.exec_idx = exec_idx_w'(i);
					dependency_clear = '0;
					dependency_clear[i] = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- cache_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl_fsm #(
	parameter int n_exec = 4
) (
	input  logic clk,
	input  logic arst_n,
	input  logic cache_fault,
	input  logic [cache_ctrl_pkg::upper_addr_w-1:0] upper_addr,
	input  logic grant_valid,
	input  cache_ctrl_pkg::ctrl_state_t next_granted,
	output cache_ctrl_pkg::ctrl_state_t skip,
	output logic allow,
	output cache_ctrl_pkg::ctrl_state_t next_state,
	output logic [n_exec-1:0] exec_ack,
	output logic fetch_ack,
	output logic lru_write,
	output logic multi_access,
	output logic no_write_override,
	output logic fault_out,
	output cache_ctrl_pkg::mask_type_e mask_type
);

	import cache_ctrl_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t step;
	logic [upper_addr_w-1:0] upper_q; // upper address of the general access in flight
	logic is_io;
	logic complete;

	assign is_io = state_q.kind == kind_general && upper_q != '0;
	assign fault_out = cache_fault && !(state_q.kind == kind_idle || is_io);
	assign allow = complete || state_q.kind == kind_idle;
	assign skip = state_q; // idle matches no requester

	always_comb begin
		complete = 1'b0;
		step = state_q;
		lru_write = 1'b0;
		multi_access = 1'b0;
		no_write_override = 1'b0;
		mask_type = mask_fetch;
		unique case (state_q.kind)
			kind_stack_first: begin
				multi_access = 1'b1;
				mask_type = mask_first_lane;
				if (!fault_out) begin
					lru_write = 1'b1;
					step.kind = kind_stack_second; // same executer, upper line
				end
			end
			kind_stack_second: begin
				multi_access = 1'b1;
				mask_type = mask_second_lane;
				if (!fault_out) begin
					lru_write = 1'b1;
					complete = 1'b1;
				end
			end
			kind_stack_single: begin
				mask_type = mask_first_lane;
				if (!fault_out) begin
					lru_write = 1'b1;
					complete = 1'b1;
				end
			end
			kind_general: begin
				mask_type = mask_general;
				if (is_io) begin
					no_write_override = 1'b1; // cache bypassed, I/O handled outside
					complete = 1'b1;
				end else if (!fault_out) begin
					lru_write = 1'b1;
					complete = 1'b1;
				end
			end
			kind_ifetch: begin
				if (!fault_out) begin
					lru_write = 1'b1;
					complete = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		next_state = step;
		if (grant_valid)
			next_state = next_granted;
		else if (complete)
			next_state = '{kind: kind_idle, exec_idx: '0};
	end

	for (genvar i = 0; i < n_exec; i++) begin : g_ack
		assign exec_ack[i] = complete && state_q.kind != kind_ifetch &&
			state_q.exec_idx == exec_idx_w'(i);
	end

	assign fetch_ack = complete && state_q.kind == kind_ifetch;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state_q <= '{kind: kind_idle, exec_idx: '0};
		else
			state_q <= next_state;
	end

	always_ff @(posedge clk) begin
		if (grant_valid && next_granted.kind == kind_general)
			upper_q <= upper_addr;
	end

endmodule

`default_nettype wire

//--- cache_addr_select.sv
`timescale 1ns/1ns
`default_nettype none

module cache_addr_select #(
	parameter int n_exec = 4
) (
	input  cache_ctrl_pkg::ctrl_state_t next_state,
	input  cache_ctrl_pkg::exec_req_t exec_req [n_exec],
	input  logic [cache_ctrl_pkg::way_addr_w-1:0] fetch_addr,
	output logic [cache_ctrl_pkg::way_addr_w-1:0] way_addr,
	output logic [cache_ctrl_pkg::upper_addr_w-1:0] upper_addr,
	output logic [cache_ctrl_pkg::stack_size_w-1:0] stack_size,
	output logic [cache_ctrl_pkg::exec_idx_w-1:0] exec_index,
	output logic byte_op,
	output logic partial_write
);

	import cache_ctrl_pkg::*;

	exec_req_t sel;
	logic [stack_addr_w-1:0] second_addr;
	logic [stack_addr_w-1:0] stack_addr;

	assign sel = exec_req[next_state.exec_idx];

	// last halfword of the access, it lands in the upper line
	assign second_addr = sel.stack_addr +
		stack_addr_w'({sel.stack_size - 1'b1, 1'b0});

	assign stack_addr = (next_state.kind == kind_stack_second) ? second_addr : sel.stack_addr;

	always_comb begin
		way_addr = {fetch_addr[way_addr_w-1:1], 1'b0};
		upper_addr = '0;
		stack_size = '0;
		exec_index = '0;
		byte_op = 1'b0;
		partial_write = 1'b0;
		unique case (next_state.kind)
			kind_stack_first, kind_stack_second, kind_stack_single: begin
				way_addr = way_addr_w'({stack_addr[stack_addr_w-1:1], 1'b0});
				stack_size = sel.stack_size;
				partial_write = sel.stack_write;
				exec_index = next_state.exec_idx;
			end
			kind_general: begin
				way_addr = sel.general_addr[way_addr_w-1:0];
				upper_addr = sel.general_addr[way_addr_w +: upper_addr_w];
				byte_op = sel.byte_op;
				partial_write = sel.general_write;
				exec_index = next_state.exec_idx;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- split_cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module split_cache_ctrl #(
	parameter int n_exec = 4
) (
	input  logic clk,
	input  logic arst_n,
	input  cache_ctrl_pkg::exec_req_t exec_req [n_exec],
	input  logic fetch_req,
	input  logic [cache_ctrl_pkg::way_addr_w-1:0] fetch_addr,
	input  logic cache_fault,
	output logic [cache_ctrl_pkg::way_addr_w-1:0] way_addr,
	output logic [cache_ctrl_pkg::upper_addr_w-1:0] upper_addr,
	output logic [cache_ctrl_pkg::stack_size_w-1:0] stack_size,
	output logic [cache_ctrl_pkg::exec_idx_w-1:0] exec_index,
	output logic byte_op,
	output logic partial_write,
	output logic [n_exec-1:0] exec_ack,
	output logic fetch_ack,
	output logic lru_write,
	output logic multi_access,
	output cache_ctrl_pkg::mask_type_e mask_type,
	output logic [n_exec-1:0] dependency_clear,
	output logic no_write_override,
	output logic fault_out
);

	import cache_ctrl_pkg::*;

	logic grant_valid;
	logic allow;
	ctrl_state_t next_granted;
	ctrl_state_t skip;
	ctrl_state_t next_state;

	cache_access_arbiter #(
		.n_exec(n_exec)
	) i_cache_access_arbiter (
		.exec_req(exec_req),
		.fetch_req(fetch_req),
		.allow(allow),
		.skip(skip),
		.grant_valid(grant_valid),
		.next_granted(next_granted),
		.dependency_clear(dependency_clear)
	);

	cache_ctrl_fsm #(
		.n_exec(n_exec)
	) i_cache_ctrl_fsm (
		.clk(clk),
		.arst_n(arst_n),
		.cache_fault(cache_fault),
		.upper_addr(upper_addr), // selected for the next cycle's access
		.grant_valid(grant_valid),
		.next_granted(next_granted),
		.skip(skip),
		.allow(allow),
		.next_state(next_state),
		.exec_ack(exec_ack),
		.fetch_ack(fetch_ack),
		.lru_write(lru_write),
		.multi_access(multi_access),
		.no_write_override(no_write_override),
		.fault_out(fault_out),
		.mask_type(mask_type)
	);

	cache_addr_select #(
		.n_exec(n_exec)
	) i_cache_addr_select (
		.next_state(next_state),
		.exec_req(exec_req),
		.fetch_addr(fetch_addr),
		.way_addr(way_addr),
		.upper_addr(upper_addr),
		.stack_size(stack_size),
		.exec_index(exec_index),
		.byte_op(byte_op),
		.partial_write(partial_write)
	);

endmodule

`default_nettype wire

//--- split_cache_ctrl_assert.sv
`timescale 1ns/1ns
`default_nettype none

module split_cache_ctrl_assert #(
	parameter int n_exec = 4
) (
	input logic clk,
	input logic arst_n,
	input cache_ctrl_pkg::ctrl_state_t state,
	input logic [n_exec-1:0] exec_ack,
	input logic fetch_ack,
	input logic lru_write,
	input logic no_write_override
);

	import cache_ctrl_pkg::*;

	a_ack_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({exec_ack, fetch_ack}))
		else $error("more than one acknowledge in one cycle");

	a_no_idle_ack: assert property (@(posedge clk) disable iff (!arst_n)
		state.kind == kind_idle |-> exec_ack == '0 && !fetch_ack)
		else $error("acknowledge raised while the controller is idle");

	a_lru_io: assert property (@(posedge clk) disable iff (!arst_n)
		!(lru_write && no_write_override))
		else $error("LRU write during an I/O bypass access");

endmodule

bind cache_ctrl_fsm split_cache_ctrl_assert #(.n_exec(n_exec)) i_split_cache_ctrl_assert (
	.clk(clk),
	.arst_n(arst_n),
	.state(state_q),
	.exec_ack(exec_ack),
	.fetch_ack(fetch_ack),
	.lru_write(lru_write),
	.no_write_override(no_write_override)
);

`default_nettype wire

//--- tb_split_cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_split_cache_ctrl;

	import cache_ctrl_pkg::*;

	localparam int n_exec = 4;
	localparam int max_wait = 20; // cycles allowed for one access

	// expected selection outputs for the access that owns the next cycle
	typedef struct packed {
		logic [way_addr_w-1:0] way;
		logic [upper_addr_w-1:0] upper;
		logic [stack_size_w-1:0] size;
		logic [exec_idx_w-1:0] idx;
		logic byte_op;
		logic partial_write;
	} sel_out_t;

	logic clk = 1'b0;
	logic arst_n;
	exec_req_t exec_req [n_exec];
	logic fetch_req;
	logic [way_addr_w-1:0] fetch_addr;
	logic cache_fault;
	logic [way_addr_w-1:0] way_addr;
	logic [upper_addr_w-1:0] upper_addr;
	logic [stack_size_w-1:0] stack_size;
	logic [exec_idx_w-1:0] exec_index;
	logic byte_op;
	logic partial_write;
	logic [n_exec-1:0] exec_ack;
	logic fetch_ack;
	logic lru_write;
	logic multi_access;
	mask_type_e mask_type;
	logic [n_exec-1:0] dependency_clear;
	logic no_write_override;
	logic fault_out;

	string test_name;
	int errors = 0;
	int timeouts = 0;
	int grant_count = 0;
	int ack_count = 0;
	int ack_order [$]; // executer index per ack or n_exec for fetch
	ctrl_state_t m_state; // expected state of the controller
	logic m_io; // expected I/O flag of the general access in flight

	split_cache_ctrl #(.n_exec(n_exec)) i_split_cache_ctrl (.*);

	always #2 clk = ~clk;

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	function automatic logic crosses_line(input exec_req_t r);
		return int'(r.stack_addr[3:1]) + int'(r.stack_size) > line_halfwords;
	endfunction

	function automatic ctrl_state_t ref_grant(input exec_req_t reqs [n_exec],
			input logic freq, input ctrl_state_t skip);
		ctrl_state_t g;
		logic skip_stack;
		g.kind = kind_idle;
		g.exec_idx = '0;
		skip_stack = skip.kind inside {kind_stack_first, kind_stack_second, kind_stack_single};
		for (int i = 0; i < n_exec; i++) begin
			if (g.kind == kind_idle && reqs[i].stack_req &&
					!(skip_stack && int'(skip.exec_idx) == i)) begin
				g.kind = crosses_line(reqs[i]) ? kind_stack_first : kind_stack_single;
				g.exec_idx = exec_idx_w'(i);
			end
			if (g.kind == kind_idle && reqs[i].general_req &&
					!(skip.kind == kind_general && int'(skip.exec_idx) == i)) begin
				g.kind = kind_general;
				g.exec_idx = exec_idx_w'(i);
			end
		end
		if (g.kind == kind_idle && freq && skip.kind != kind_ifetch)
			g.kind = kind_ifetch;
		return g;
	endfunction

	function automatic sel_out_t ref_select(input ctrl_state_t s,
			input exec_req_t reqs [n_exec], input logic [way_addr_w-1:0] faddr);
		sel_out_t e;
		exec_req_t r;
		logic [stack_addr_w-1:0] a;
		r = reqs[s.exec_idx];
		e = '0;
		e.way = {faddr[way_addr_w-1:1], 1'b0};
		a = r.stack_addr;
		if (s.kind == kind_stack_second)
			a = r.stack_addr + stack_addr_w'((int'(r.stack_size) - 1) * 2); // last halfword
		case (s.kind)
			kind_stack_first, kind_stack_second, kind_stack_single: begin
				e.way = way_addr_w'({a[stack_addr_w-1:1], 1'b0});
				e.size = r.stack_size;
				e.idx = s.exec_idx;
				e.partial_write = r.stack_write;
			end
			kind_general: begin
				e.way = r.general_addr[way_addr_w-1:0];
				e.upper = r.general_addr[way_addr_w +: upper_addr_w];
				e.idx = s.exec_idx;
				e.byte_op = r.byte_op;
				e.partial_write = r.general_write;
			end
			default: begin
			end
		endcase
		return e;
	endfunction

	always @(negedge clk) begin : compare
		ctrl_state_t g;
		ctrl_state_t nxt;
		sel_out_t exp_sel;
		mask_type_e exp_mask;
		logic fe;
		logic comp;
		logic lru;
		logic multi;
		logic [n_exec-1:0] exp_dc;
		logic [n_exec-1:0] exp_ack;
		if (!arst_n) begin
			m_state.kind = kind_idle;
			m_state.exec_idx = '0;
			m_io = 1'b0;
		end else begin
			fe = cache_fault && m_state.kind != kind_idle &&
				!(m_state.kind == kind_general && m_io);
			comp = 1'b0;
			multi = m_state.kind inside {kind_stack_first, kind_stack_second};
			lru = !fe && m_state.kind != kind_idle && !(m_state.kind == kind_general && m_io);
			nxt = m_state;
			if (m_state.kind == kind_stack_first && !fe)
				nxt.kind = kind_stack_second;
			else if (m_state.kind != kind_stack_first && m_state.kind != kind_idle)
				comp = !fe;
			g.kind = kind_idle;
			g.exec_idx = '0;
			if (comp || m_state.kind == kind_idle)
				g = ref_grant(exec_req, fetch_req, m_state);
			if (g.kind != kind_idle)
				nxt = g;
			else if (comp)
				nxt.kind = kind_idle;
			exp_dc = '0;
			if (g.kind != kind_idle && g.kind != kind_ifetch)
				exp_dc[g.exec_idx] = 1'b1;
			exp_ack = '0;
			if (comp && m_state.kind != kind_ifetch)
				exp_ack[m_state.exec_idx] = 1'b1;
			exp_mask = mask_fetch;
			if (m_state.kind inside {kind_stack_first, kind_stack_single})
				exp_mask = mask_first_lane;
			else if (m_state.kind == kind_stack_second)
				exp_mask = mask_second_lane;
			else if (m_state.kind == kind_general)
				exp_mask = mask_general;
			exp_sel = ref_select(nxt, exec_req, fetch_addr);
			check("dependency_clear", 32'(exp_dc), 32'(dependency_clear));
			check("exec_ack", 32'(exp_ack), 32'(exec_ack));
			check("fetch_ack", 32'(comp && m_state.kind == kind_ifetch), 32'(fetch_ack));
			check("lru_write", 32'(lru), 32'(lru_write));
			check("no_write_override", 32'(m_state.kind == kind_general && m_io),
				32'(no_write_override));
			check("multi_access", 32'(multi), 32'(multi_access));
			if (m_state.kind != kind_idle)
				check("mask_type", 32'(exp_mask), 32'(mask_type));
			check("fault_out", 32'(fe), 32'(fault_out));
			check("way_addr", 32'(exp_sel.way), 32'(way_addr));
			check("upper_addr", 32'(exp_sel.upper), 32'(upper_addr));
			check("stack_size", 32'(exp_sel.size), 32'(stack_size));
			check("exec_index", 32'(exp_sel.idx), 32'(exec_index));
			check("byte_op", 32'(exp_sel.byte_op), 32'(byte_op));
			check("partial_write", 32'(exp_sel.partial_write), 32'(partial_write));
			if (g.kind == kind_general)
				m_io = exec_req[g.exec_idx].general_addr[way_addr_w +: upper_addr_w] != '0;
			if (g.kind != kind_idle)
				grant_count++;
			m_state = nxt;
			ack_count += $countones(exec_ack) + int'(fetch_ack);
		end
	end

	function automatic exec_req_t make_stack(input logic [stack_addr_w-1:0] addr,
			input logic [stack_size_w-1:0] size, input logic write);
		exec_req_t r;
		r = '0;
		r.stack_req = 1'b1;
		r.stack_write = write;
		r.stack_size = size;
		r.stack_addr = addr;
		return r;
	endfunction

	function automatic exec_req_t make_general(input logic [31:0] addr, input logic write,
			input logic byte_sel);
		exec_req_t r;
		r = '0;
		r.general_req = 1'b1;
		r.general_write = write;
		r.byte_op = byte_sel;
		r.general_addr = addr;
		return r;
	endfunction

	function automatic exec_req_t random_req();
		logic [upper_addr_w-1:0] upper;
		upper = ($urandom % 4 == 0) ? upper_addr_w'($urandom) : '0; // some I/O accesses
		if ($urandom % 2 == 0)
			return make_stack(stack_addr_w'($urandom), stack_size_w'($urandom), 1'($urandom));
		return make_general({upper, way_addr_w'($urandom)}, 1'($urandom), 1'($urandom));
	endfunction

	function automatic logic pending();
		logic p;
		p = fetch_req;
		foreach (exec_req[i])
			p = p | exec_req[i].stack_req | exec_req[i].general_req;
		return p;
	endfunction

	// one access alone with the fault held for fault_n cycles after the grant
	task automatic run_access(input int idx, input exec_req_t r, input int fault_n,
			input int exp_lat);
		int cyc;
		logic done;
		cyc = 0;
		done = 1'b0;
		@(posedge clk);
		#1;
		if (idx < 0)
			fetch_req = 1'b1;
		else
			exec_req[idx] = r;
		while (!done && cyc <= max_wait) begin
			@(negedge clk);
			if (cyc == 0 && idx >= 0)
				check("grant_pulse", 32'd1, 32'(dependency_clear[idx]));
			done = (idx < 0) ? fetch_ack : exec_ack[idx];
			@(posedge clk);
			#1;
			if (!done) begin
				cyc++;
				cache_fault = cyc <= fault_n;
			end
		end
		cache_fault = 1'b0;
		if (idx < 0)
			fetch_req = 1'b0;
		else
			exec_req[idx] = '0;
		if (done) begin
			check("ack_latency", 32'(exp_lat), 32'(cyc));
		end else begin
			timeouts++;
			$display("timeout: no acknowledge within %0d cycles in %s", max_wait, test_name);
		end
	endtask

	// drops each request after its ack and may raise new random ones
	task automatic step_requests(input logic random_new, input int max_cyc);
		int cyc;
		logic [n_exec-1:0] acked;
		logic fetch_acked;
		cyc = 0;
		while ((random_new || pending()) && cyc < max_cyc) begin
			@(negedge clk);
			acked = exec_ack;
			fetch_acked = fetch_ack;
			@(posedge clk);
			#1;
			cyc++;
			for (int i = 0; i < n_exec; i++) begin
				if (acked[i]) begin
					exec_req[i].stack_req = 1'b0;
					exec_req[i].general_req = 1'b0;
					ack_order.push_back(i);
				end
				if (random_new && !exec_req[i].stack_req && !exec_req[i].general_req &&
						$urandom % 3 == 0)
					exec_req[i] = random_req();
			end
			if (fetch_acked) begin
				fetch_req = 1'b0;
				ack_order.push_back(n_exec);
			end
			if (random_new && !fetch_req && $urandom % 4 == 0) begin
				fetch_addr = way_addr_w'($urandom);
				fetch_req = 1'b1;
			end
			if (random_new)
				cache_fault = $urandom % 4 == 0;
		end
		cache_fault = 1'b0;
		if (!random_new && pending()) begin
			timeouts++;
			$display("timeout: requests still pending after %0d cycles in %s", max_cyc, test_name);
		end
	endtask

	initial begin
		void'($urandom(32'h75c));
		arst_n = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		cache_fault = 1'b0;
		foreach (exec_req[i])
			exec_req[i] = '0;
		test_name = "reset";
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;

		test_name = "single_access";
		run_access(0, make_stack(16'h0102, 3'd2, 1'b0), 0, 1);
		run_access(1, make_general(32'h0012_3456, 1'b1, 1'b1), 0, 1);
		fetch_addr = 26'h2a5_5a5b;
		run_access(-1, '0, 0, 1);

		test_name = "split_stack";
		run_access(2, make_stack(16'h001c, 3'd4, 1'b1), 0, 2);

		test_name = "priority";
		ack_order.delete();
		@(posedge clk);
		#1;
		exec_req[3] = make_general(32'h0000_0400, 1'b0, 1'b0);
		exec_req[2] = make_stack(16'h0020, 3'd1, 1'b1);
		exec_req[1] = make_stack(16'h003e, 3'd2, 1'b0); // crosses into the next line
		exec_req[0] = make_general(32'h0100_0020, 1'b1, 1'b0);
		fetch_req = 1'b1;
		step_requests(1'b0, 100);
		check("ack_count", 32'd5, 32'(ack_order.size()));
		foreach (ack_order[k])
			check("ack_order", 32'(k), 32'(ack_order[k]));

		test_name = "fault_stall";
		run_access(0, make_stack(16'h0040, 3'd1, 1'b0), 3, 4);
		run_access(3, make_stack(16'h000e, 3'd3, 1'b1), 2, 4);
		run_access(-1, '0, 1, 2);

		test_name = "io_bypass";
		run_access(1, make_general(32'h8000_0100, 1'b1, 1'b0), 3, 1);
		run_access(2, make_general(32'h0400_0000, 1'b0, 1'b1), 0, 1);

		test_name = "random_mix";
		step_requests(1'b1, 400);
		step_requests(1'b0, 200);
		check("acks_vs_grants", 32'(grant_count), 32'(ack_count));

		repeat (2) @(posedge clk);
		$display("checks failed: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- split_cache_ctrl.f
cache_ctrl_pkg.sv
cache_access_arbiter.sv
cache_ctrl_fsm.sv
cache_addr_select.sv
split_cache_ctrl.sv
split_cache_ctrl_assert.sv
tb_split_cache_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_split_cache_ctrl \
	-Mdir "$build_dir" -o sim \
	-f split_cache_ctrl.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
fi

if grep -qxF "=== PASS ===" "$log_file"; then
	exit 0
fi
echo "=== FAIL ==="
exit 1
